//--- hdl/xbus_pkg.sv
// Bus address map, disk command codes, IDE register selects and arbiter state type
package xbus_pkg;

   // One-hot arbiter state
   typedef enum logic [3:0] {
      bus_idle  = 4'b0001,
      bus_req   = 4'b0010,
      bus_wait  = 4'b0100,
      bus_slave = 4'b1000
   } bus_state_t;

   // 22-bit word address map, octal as in the processor documentation
   localparam logic [21:0] XBUS_LO      = 22'o17000000;  // DRAM lives below this
   localparam logic [21:0] UNIBUS_LO    = 22'o17400000;
   localparam logic [21:0] DISK_BASE    = 22'o17377770;  // 4 registers
   localparam logic [21:0] IO_BASE      = 22'o17772000;  // 2 registers
   localparam logic [21:0] MODE_REG     = 22'o17766012;
   localparam logic [21:0] INT_STAT_REG = 22'o17766040;

   // Command field of disk register 0
   localparam logic [1:0] DISK_CMD_READ  = 2'd1;  // IDE to DRAM
   localparam logic [1:0] DISK_CMD_WRITE = 2'd2;  // DRAM to IDE

   // IDE register selects on ide_da
   localparam logic [2:0] IDE_REG_DATA = 3'd0;
   localparam logic [2:0] IDE_REG_LBA  = 3'd3;

   localparam int IDE_WORDS_PER_BLOCK = 256;  // 16-bit words

endpackage

//--- hdl/xbus_ram.sv
// Word-addressed DRAM slave with fixed acknowledge latency
`timescale 1ns/10ps

module xbus_ram
   import xbus_pkg::*;
#(
   parameter int DRAM_AWIDTH = 12,
   parameter int RAM_LATENCY = 2  // At least 1
)
(
   input  logic        mclk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   output logic [31:0] dataout,
   input  logic        req,
   input  logic        write,
   output logic        ack,
   output logic        decode
);

   localparam int CW = $clog2(RAM_LATENCY + 1);

   logic [31:0]            mem [2**DRAM_AWIDTH];
   logic [DRAM_AWIDTH-1:0] word_addr;
   logic [CW-1:0]          wait_cnt;
   logic                   busy;   // Request already answered
   logic                   fire;   // Last wait cycle, ack follows

   assign word_addr = addr[DRAM_AWIDTH-1:0];
   assign decode    = addr < XBUS_LO && addr[21:DRAM_AWIDTH] == '0;
   assign fire      = req && decode && !busy && wait_cnt == CW'(RAM_LATENCY - 1);

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         wait_cnt <= '0;
         busy     <= 1'b0;
         ack      <= 1'b0;
      end
      else if (req && decode)
      begin
         ack <= fire;
         if (fire)
         begin
            busy     <= 1'b1;
            wait_cnt <= '0;
         end
         else if (!busy)
            wait_cnt <= wait_cnt + 1'b1;
      end
      else
      begin
         // Requester dropped req, ready for the next access
         wait_cnt <= '0;
         busy     <= 1'b0;
         ack      <= 1'b0;
      end
   end

   always_ff @(posedge mclk)
   begin
      if (ack && write)
         mem[word_addr] <= datain;
      if (fire)
         dataout <= mem[word_addr];  // Valid from the ack cycle on
   end

   a_ack_req: assert property (@(posedge mclk) disable iff (reset) ack |-> req && decode);

endmodule

//--- hdl/xbus_disk.sv
// Disk controller with register file, IDE programmed-I/O sequencer and DMA bus master
`timescale 1ns/10ps

module xbus_disk
   import xbus_pkg::*;
(
   input  logic        mclk,
   input  logic        reset,
   input  logic [21:0] addrin,
   output logic [21:0] addrout,
   input  logic [31:0] datain,
   output logic [31:0] dataout,
   input  logic        reqin,
   output logic        reqout,
   input  logic        grantin,
   output logic        ack,
   input  logic        writein,
   output logic        writeout,
   input  logic        decodein,  // Disk owns the DRAM this cycle
   output logic        decode,
   output logic        interrupt,
   input  logic [15:0] ide_data_in,
   output logic [15:0] ide_data_out,
   output logic        ide_dior,
   output logic        ide_diow,
   output logic [1:0]  ide_cs,
   output logic [2:0]  ide_da
);

   localparam logic [2:0] ST_IDLE  = 3'd0;
   localparam logic [2:0] ST_LBA   = 3'd1;  // Block number to the drive
   localparam logic [2:0] ST_FETCH = 3'd2;  // DRAM read as master
   localparam logic [2:0] ST_XFER  = 3'd3;  // Two 16-bit IDE data strobes
   localparam logic [2:0] ST_STORE = 3'd4;  // DRAM write as master

   localparam logic [2:0] STROBE_LAST = 3'd3;  // Strobe high for 4 cycles
   localparam logic [2:0] STEP_LAST   = 3'd5;  // Then 2 idle cycles

   logic [2:0]  state;
   logic [2:0]  tcnt;
   logic        half;        // High half of the word on the IDE side
   logic        cmd_write;
   logic        done;
   logic        int_enable;
   logic        acked;
   logic        access, start, busy, ide_phase, step_end, capture, word_done;
   logic [21:0] dma_addr;
   logic [15:0] word_count;  // 32-bit words left
   logic [15:0] block;
   logic [31:0] word;
   logic [31:0] reg_data;

   assign decode    = addrin[21:2] == DISK_BASE[21:2];
   assign access    = reqin && decode && !acked;
   assign busy      = state != ST_IDLE;
   assign start     = access && writein && addrin[1:0] == 2'd0 && !busy &&
                      (datain[1:0] == DISK_CMD_READ || datain[1:0] == DISK_CMD_WRITE);
   assign ide_phase = state == ST_LBA || state == ST_XFER;
   assign step_end  = ide_phase && tcnt == STEP_LAST;
   assign capture   = state == ST_XFER && !cmd_write && tcnt == STROBE_LAST;
   assign word_done = (state == ST_STORE && grantin) ||
                      (state == ST_XFER && step_end && half && cmd_write);
   assign interrupt = done && int_enable;

   // DMA master side
   assign reqout   = state == ST_FETCH || state == ST_STORE;
   assign writeout = state == ST_STORE;
   assign addrout  = dma_addr;
   assign dataout  = decodein ? word : reg_data;

   always_comb
   begin
      case (addrin[1:0])
         2'd0:    reg_data = {30'd0, done, busy};
         2'd1:    reg_data = {10'd0, dma_addr};
         2'd2:    reg_data = {16'd0, word_count};
         default: reg_data = {16'd0, block};
      endcase
   end

   // IDE pins, strobes are active high
   assign ide_diow     = ide_phase && tcnt <= STROBE_LAST && (state == ST_LBA || cmd_write);
   assign ide_dior     = state == ST_XFER && tcnt <= STROBE_LAST && !cmd_write;
   assign ide_cs       = {1'b0, ide_phase};
   assign ide_da       = state == ST_LBA ? IDE_REG_LBA : IDE_REG_DATA;
   assign ide_data_out = state == ST_LBA ? block : (half ? word[31:16] : word[15:0]);

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         state      <= ST_IDLE;
         tcnt       <= '0;
         half       <= 1'b0;
         cmd_write  <= 1'b0;
         done       <= 1'b0;
         int_enable <= 1'b0;
         ack        <= 1'b0;
         acked      <= 1'b0;
      end
      else
      begin
         ack   <= access;
         acked <= reqin && decode;
         tcnt  <= (ide_phase && !step_end) ? tcnt + 1'b1 : 3'd0;

         if (access && writein && addrin[1:0] == 2'd0)
         begin
            int_enable <= datain[2];
            done       <= 1'b0;
         end

         case (state)
            ST_IDLE:
               if (start)
               begin
                  state     <= ST_LBA;
                  cmd_write <= datain[1:0] == DISK_CMD_WRITE;
               end
            ST_LBA:
               if (step_end)
               begin
                  half <= 1'b0;
                  if (word_count == 16'd0)
                  begin
                     state <= ST_IDLE;
                     done  <= 1'b1;
                  end
                  else
                     state <= cmd_write ? ST_FETCH : ST_XFER;
               end
            ST_FETCH:
               if (grantin)
                  state <= ST_XFER;
            ST_XFER:
               if (step_end && !half)
                  half <= 1'b1;
               else if (step_end && !cmd_write)
                  state <= ST_STORE;
            ST_STORE: ;                  // Left through word_done
            default:
               state <= ST_IDLE;
         endcase

         if (word_done)
         begin
            half <= 1'b0;
            if (word_count == 16'd1)
            begin
               state <= ST_IDLE;
               done  <= 1'b1;
            end
            else
               state <= cmd_write ? ST_FETCH : ST_XFER;
         end
      end
   end

   always_ff @(posedge mclk)
   begin
      if (access && writein)
      begin
         case (addrin[1:0])
            2'd1:    dma_addr   <= datain[21:0];
            2'd2:    word_count <= datain[15:0];
            2'd3:    block      <= datain[15:0];
            default: ;
         endcase
      end
      if (word_done)
      begin
         dma_addr   <= dma_addr + 1'b1;
         word_count <= word_count - 1'b1;
      end
      if (state == ST_FETCH && grantin)
         word <= datain;               // DRAM data is valid in the grant cycle
      else if (capture && !half)
         word[15:0] <= ide_data_in;    // Low half comes first
      else if (capture)
         word[31:16] <= ide_data_in;
   end

   a_req_hold: assert property (@(posedge mclk) disable iff (reset)
      reqout && !grantin |=> reqout);

endmodule

//--- hdl/xbus_io.sv
// I/O board slave with tick counter, interrupt enable and pending flag
`timescale 1ns/10ps

module xbus_io
   import xbus_pkg::*;
#(
   parameter int TICK_CYCLES = 64  // At least 2
)
(
   input  logic        mclk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   output logic [31:0] dataout,
   input  logic        req,
   input  logic        write,
   output logic        ack,
   output logic        decode,
   output logic        interrupt
);

   localparam int TW = $clog2(TICK_CYCLES);

   logic [TW-1:0] tick_div;
   logic [15:0]   tick_count;  // Ticks since reset
   logic          tick;
   logic          pending;
   logic          enable;
   logic          acked;
   logic          access;

   assign decode    = addr[21:1] == IO_BASE[21:1];
   assign access    = req && decode && !acked;
   assign tick      = tick_div == TW'(TICK_CYCLES - 1);
   assign interrupt = pending && enable;

   // Offset 0 enable, offset 1 tick count and pending
   assign dataout = addr[0] ? {tick_count, 15'd0, pending} : {31'd0, enable};

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         tick_div   <= '0;
         tick_count <= '0;
         pending    <= 1'b0;
         enable     <= 1'b0;
         ack        <= 1'b0;
         acked      <= 1'b0;
      end
      else
      begin
         ack      <= access;
         acked    <= req && decode;
         tick_div <= tick ? '0 : tick_div + 1'b1;

         if (tick)
            tick_count <= tick_count + 1'b1;

         if (tick)
            pending <= 1'b1;     // A new tick beats a clear in the same cycle
         else if (access && write && addr[0])
            pending <= 1'b0;

         if (access && write && !addr[0])
            enable <= datain[0];
      end
   end

endmodule

//--- hdl/xbus_unibus.sv
// Unibus register block with mode register and interrupt status register
`timescale 1ns/10ps

module xbus_unibus
   import xbus_pkg::*;
(
   input  logic        mclk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   output logic [31:0] dataout,
   input  logic        req,
   input  logic        write,
   output logic        ack,
   output logic        decode,
   output logic        interrupt,
   output logic        promdisable
);

   logic [15:0] mode_reg;
   logic        sw_req;       // Software interrupt request, status bit 0
   logic        int_enable;   // Status bit 1
   logic        acked;
   logic        access;

   // Unibus window stops where the I/O board starts
   assign decode      = addr >= UNIBUS_LO && addr < IO_BASE;
   assign access      = req && decode && !acked;
   assign promdisable = mode_reg[0];
   assign interrupt   = sw_req;

   assign dataout = (addr == MODE_REG)     ? {16'd0, mode_reg} :
                    (addr == INT_STAT_REG) ? {30'd0, int_enable, sw_req} :
                    32'd0;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         mode_reg   <= '0;
         sw_req     <= 1'b0;
         int_enable <= 1'b0;
         ack        <= 1'b0;
         acked      <= 1'b0;
      end
      else
      begin
         ack   <= access;        // Any decoded address is answered
         acked <= req && decode;
         if (access && write && addr == MODE_REG)
            mode_reg <= datain[15:0];
         if (access && write && addr == INT_STAT_REG)
         begin
            sw_req     <= datain[0];
            int_enable <= datain[1];
         end
      end
   end

endmodule

//--- hdl/busint.sv
// Bus interface top with slave instances, arbiter FSM, DMA multiplexing and merging
`timescale 1ns/10ps

module busint
   import xbus_pkg::*;
#(
   parameter int DRAM_AWIDTH = 12,
   parameter int RAM_LATENCY = 2,
   parameter int TICK_CYCLES = 64
)
(
   input  logic        mclk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] busin,
   output logic [31:0] busout,
   input  logic        req,
   output logic        ack,
   input  logic        write,
   output logic        load,
   output logic        interrupt,
   input  logic [15:0] ide_data_in,
   output logic [15:0] ide_data_out,
   output logic        ide_dior,
   output logic        ide_diow,
   output logic [1:0]  ide_cs,
   output logic [2:0]  ide_da,
   output logic        promdisable
);

   bus_state_t  state;
   bus_state_t  next_state;

   logic        slave_req;     // Processor request as the slaves see it
   logic        in_slave;      // Disk owns the DRAM
   logic        device_ack;

   logic        decode_dram, decode_disk, decode_io, decode_unibus;
   logic        ack_dram, ack_disk, ack_io, ack_unibus;
   logic        int_disk, int_io, int_unibus;
   logic [31:0] dataout_dram, dataout_disk, dataout_io, dataout_unibus;

   logic [21:0] dram_addr;
   logic [31:0] dram_datain;
   logic        dram_req;
   logic        dram_write;

   logic [21:0] disk_addrout;
   logic [31:0] disk_datain;
   logic        disk_reqout;
   logic        disk_writeout;
   logic        disk_grant;

   assign in_slave  = state == bus_slave;
   assign slave_req = req && state == bus_req;

   // DRAM is shared between the processor and disk DMA
   assign dram_addr   = in_slave ? disk_addrout  : addr;
   assign dram_datain = in_slave ? dataout_disk  : busin;
   assign dram_req    = in_slave ? disk_reqout   : slave_req;
   assign dram_write  = in_slave ? disk_writeout : write;
   assign disk_datain = in_slave ? dataout_dram  : busin;

   xbus_ram #(
      .DRAM_AWIDTH(DRAM_AWIDTH),
      .RAM_LATENCY(RAM_LATENCY)
   ) dram (
      .mclk(mclk),
      .reset(reset),
      .addr(dram_addr),
      .datain(dram_datain),
      .dataout(dataout_dram),
      .req(dram_req),
      .write(dram_write),
      .ack(ack_dram),
      .decode(decode_dram)
   );

   xbus_disk disk (
      .mclk(mclk),
      .reset(reset),
      .addrin(addr),
      .addrout(disk_addrout),
      .datain(disk_datain),
      .dataout(dataout_disk),
      .reqin(slave_req),
      .reqout(disk_reqout),
      .grantin(disk_grant),
      .ack(ack_disk),
      .writein(write),
      .writeout(disk_writeout),
      .decodein(in_slave),
      .decode(decode_disk),
      .interrupt(int_disk),
      .ide_data_in(ide_data_in),
      .ide_data_out(ide_data_out),
      .ide_dior(ide_dior),
      .ide_diow(ide_diow),
      .ide_cs(ide_cs),
      .ide_da(ide_da)
   );

   xbus_io #(
      .TICK_CYCLES(TICK_CYCLES)
   ) io (
      .mclk(mclk),
      .reset(reset),
      .addr(addr),
      .datain(busin),
      .dataout(dataout_io),
      .req(slave_req),
      .write(write),
      .ack(ack_io),
      .decode(decode_io),
      .interrupt(int_io)
   );

   xbus_unibus unibus (
      .mclk(mclk),
      .reset(reset),
      .addr(addr),
      .datain(busin),
      .dataout(dataout_unibus),
      .req(slave_req),
      .write(write),
      .ack(ack_unibus),
      .decode(decode_unibus),
      .interrupt(int_unibus),
      .promdisable(promdisable)
   );

   assign device_ack = ack_dram | ack_disk | ack_io | ack_unibus;
   assign ack        = state == bus_req && device_ack;
   assign load       = req && !write && state == bus_wait;
   assign disk_grant = in_slave && ack_dram;     // Same edge that returns to idle
   assign interrupt  = int_disk | int_io | int_unibus;

   assign busout = (req && !write && decode_dram)   ? dataout_dram   :
                   (req && !write && decode_disk)   ? dataout_disk   :
                   (req && !write && decode_io)     ? dataout_io     :
                   (req && !write && decode_unibus) ? dataout_unibus :
                   32'hffffffff;

   // Arbiter, processor wins over a pending DMA word
   always_comb
   begin
      next_state = state;
      case (state)
         bus_idle:
            if (req)
               next_state = bus_req;
            else if (disk_reqout)
               next_state = bus_slave;
         bus_req:
            if (device_ack)
               next_state = bus_wait;
         bus_wait:
            if (!req)
               next_state = bus_idle;
         bus_slave:
            if (ack_dram)
               next_state = bus_idle;
         default:
            next_state = bus_idle;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         state <= bus_idle;
      else
         state <= next_state;
   end

   a_state_onehot: assert property (@(posedge mclk) disable iff (reset) $onehot(state));

   // Register slaves only ever answer a processor access
   a_slave_ack: assert property (@(posedge mclk) disable iff (reset)
      (ack_disk || ack_io || ack_unibus) |-> state == bus_req);

endmodule

//--- testbench/tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/10ps

module tb_clock
(
   output logic mclk,
   output logic reset
);

   initial
   begin
      mclk = 1'b0;
      forever #5 mclk = ~mclk;  // 10 ns period
   end

   initial
   begin
      reset = 1'b1;
      repeat (8) @(posedge mclk);
      #1 reset = 1'b0;          // Released just after an edge
   end

endmodule

//--- testbench/ide_drive_model.sv
// Behavioral IDE drive with block-addressed 16-bit word storage
`timescale 1ns/10ps

module ide_drive_model
   import xbus_pkg::*;
(
   input  logic        mclk,
   input  logic        ide_dior,
   input  logic        ide_diow,
   input  logic [1:0]  ide_cs,
   input  logic [2:0]  ide_da,
   input  logic [15:0] ide_data_out,  // Host to drive
   output logic [15:0] ide_data_in    // Drive to host
);

   localparam int BLOCKS = 4;

   logic [15:0] mem [BLOCKS*IDE_WORDS_PER_BLOCK];
   logic [15:0] block;
   logic        dior_q;
   logic        diow_q;
   int          ptr;     // Word within the block
   int          index;

   initial
   begin
      for (int i = 0; i < BLOCKS*IDE_WORDS_PER_BLOCK; i++)
         mem[i] = 16'(i) ^ 16'ha5a5;
      block  = '0;
      ptr    = 0;
      dior_q = 1'b0;
      diow_q = 1'b0;
   end

   always_comb
      index = (int'(block) % BLOCKS) * IDE_WORDS_PER_BLOCK + ptr;

   assign ide_data_in = mem[index];

   always @(posedge mclk)
   begin
      dior_q <= ide_dior;
      diow_q <= ide_diow;
      if (ide_cs[0] && ide_diow && !diow_q)    // Start of a write strobe
      begin
         if (ide_da == IDE_REG_LBA)
         begin
            block <= ide_data_out;
            ptr   <= 0;
         end
         else if (ide_da == IDE_REG_DATA)
         begin
            mem[index] <= ide_data_out;
            ptr        <= (ptr + 1) % IDE_WORDS_PER_BLOCK;
         end
      end
      if (dior_q && !ide_dior)
         ptr <= (ptr + 1) % IDE_WORDS_PER_BLOCK;  // Read word taken, move on
   end

endmodule

//--- testbench/busint_tb.sv
// Testbench top for busint, vector-driven bus accesses, interrupt waits and disk polling
`timescale 1ns/10ps

module busint_tb
   import xbus_pkg::*;
();

   localparam int TICK_CYCLES = 64;
   localparam int ACK_TIMEOUT = 64;   // Cycles per bus access
   localparam int POLL_LIMIT  = 200;  // Status reads per disk operation
   localparam int RESET_LIMIT = 40;

   logic        mclk;
   logic        reset;
   logic [21:0] addr;
   logic [31:0] busin;
   logic [31:0] busout;
   logic        req;
   logic        ack;
   logic        write;
   logic        load;
   logic        interrupt;
   logic [15:0] ide_data_in;
   logic [15:0] ide_data_out;
   logic        ide_dior;
   logic        ide_diow;
   logic [1:0]  ide_cs;
   logic [2:0]  ide_da;
   logic        promdisable;

   int fd;
   int op_no;  // Operation count for error lines

   tb_clock clock_gen (.mclk(mclk), .reset(reset));

   busint #(
      .DRAM_AWIDTH(12),
      .RAM_LATENCY(2),
      .TICK_CYCLES(TICK_CYCLES)
   ) uut (
      .mclk(mclk), .reset(reset), .addr(addr), .busin(busin), .busout(busout),
      .req(req), .ack(ack), .write(write), .load(load), .interrupt(interrupt),
      .ide_data_in(ide_data_in), .ide_data_out(ide_data_out), .ide_dior(ide_dior),
      .ide_diow(ide_diow), .ide_cs(ide_cs), .ide_da(ide_da), .promdisable(promdisable)
   );

   ide_drive_model drive (
      .mclk(mclk), .ide_dior(ide_dior), .ide_diow(ide_diow), .ide_cs(ide_cs),
      .ide_da(ide_da), .ide_data_out(ide_data_out), .ide_data_in(ide_data_in)
   );

   task automatic abort_run(input string why);
      $display("%s (operation %0d)", why, op_no);
      $display("test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("ERR %s: got %h, expected %h", name, actual, expected);
         abort_run("value mismatch");
      end
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (reset !== 1'b0)
      begin
         if (cycles == RESET_LIMIT)
            abort_run("reset was never released");
         else
         begin
            @(posedge mclk);
            cycles++;
         end
      end
   endtask

   // One processor access that returns busout in q while load is up
   task automatic bus_access(input logic is_write, input logic [21:0] a,
                             input logic [31:0] d, output logic [31:0] q);
      int cycles;
      cycles = 0;
      @(posedge mclk);
      #1;
      addr  = a;
      write = is_write;
      busin = d;
      req   = 1'b1;
      @(negedge mclk);
      while (ack !== 1'b1)
      begin
         if (cycles == ACK_TIMEOUT)
            abort_run("no ack on the bus within the timeout");
         else
         begin
            @(negedge mclk);
            cycles++;
         end
      end
      @(negedge mclk);
      check("ack", {31'd0, ack}, 32'd0);          // Single pulse
      check("load", {31'd0, load}, {31'd0, !is_write});
      q = busout;
      @(negedge mclk);
      check("ack", {31'd0, ack}, 32'd0);
      check("load", {31'd0, load}, {31'd0, !is_write});  // Held until req drops
      @(posedge mclk);
      #1;
      req   = 1'b0;
      write = 1'b0;
   endtask

   task automatic wait_interrupt(input logic level, input int limit);
      int cycles;
      cycles = 0;
      while (interrupt !== level)
      begin
         if (cycles == limit)
            abort_run("interrupt did not reach the expected level in time");
         else
         begin
            @(negedge mclk);
            cycles++;
         end
      end
   endtask

   task automatic hold_interrupt(input logic level, input int span);
      for (int i = 0; i < span; i++)
      begin
         @(negedge mclk);
         check("interrupt", {31'd0, interrupt}, {31'd0, level});
      end
   endtask

   task automatic poll_until(input logic [21:0] a, input logic [31:0] expected);
      logic [31:0] q;
      int          tries;
      tries = 0;
      bus_access(1'b0, a, 32'd0, q);
      while (q !== expected)
      begin
         if (tries == POLL_LIMIT)
            abort_run("status register never reached the expected value");
         else
         begin
            @(posedge mclk);  // Idle bus cycle lets a waiting DMA word win the arbiter
            bus_access(1'b0, a, 32'd0, q);
            tries++;
         end
      end
   endtask

   task automatic run_op(input logic [7:0] op, input logic [21:0] a,
                         input logic [31:0] d, input logic [31:0] e);
      logic [31:0] q;
      case (op)
         "W":
         begin
            bus_access(1'b1, a, d, q);
            if (a == MODE_REG)
               check("promdisable", {31'd0, promdisable}, {31'd0, d[0]});
         end
         "R":
         begin
            bus_access(1'b0, a, 32'd0, q);
            check("busout", q, e);
         end
         "T":
            if (a[0])
               hold_interrupt(e[0], int'(d));
            else
               wait_interrupt(e[0], int'(d));
         "D":
            poll_until(a, e);
         default:
            abort_run("unknown operation letter in the vector file");
      endcase
   endtask

   task automatic run_vectors();
      int                r;
      logic [7:0]        op;
      logic [31:0]       a, d, e;
      logic [8*160-1:0]  rest;
      r = $fscanf(fd, " %c", op);
      while (r == 1)
      begin
         if (op == "#")
            r = $fgets(rest, fd);            // Skip a comment line
         else
         begin
            op_no++;
            r = $fscanf(fd, " %h %h %h", a, d, e);
            if (r != 3)
               abort_run("malformed line in the vector file");
            else
               run_op(op, a[21:0], d, e);
         end
         r = $fscanf(fd, " %c", op);
      end
   endtask

   initial
   begin
      addr  = '0;
      busin = '0;
      req   = 1'b0;
      write = 1'b0;
      op_no = 0;
      fd    = $fopen("testbench/busint_vectors.txt", "r");
      if (fd == 0)
         abort_run("cannot open testbench/busint_vectors.txt");
      else
      begin
         wait_reset_release();
         @(negedge mclk);
         check("ack", {31'd0, ack}, 32'd0);
         check("load", {31'd0, load}, 32'd0);
         check("interrupt", {31'd0, interrupt}, 32'd0);
         check("promdisable", {31'd0, promdisable}, 32'd0);
         check("ide_dior", {31'd0, ide_dior}, 32'd0);
         check("ide_diow", {31'd0, ide_diow}, 32'd0);
         run_vectors();
         $fclose(fd);
         $display("test passed");
         $finish;
      end
   end

endmodule

//--- caddr_bus.f
hdl/xbus_pkg.sv
hdl/xbus_ram.sv
hdl/xbus_disk.sv
hdl/xbus_io.sv
hdl/xbus_unibus.sv
hdl/busint.sv
testbench/tb_clock.sv
testbench/ide_drive_model.sv
testbench/busint_tb.sv

//--- Makefile
# Verilator build and run of the busint testbench

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module busint_tb \
		-f caddr_bus.f -Mdir obj_dir -o busint_tb
	./obj_dir/busint_tb

clean:
	rm -rf obj_dir

//--- testbench/busint_vectors.txt
# Columns: op addr data expect, all hex. W write, R read and check busout, D read until expect
# T addr 0 waits up to data cycles for interrupt == expect, T addr 1 holds it for data cycles
W 000000 0badcafe 0
W 000fff 12345678 0
R 000000 0 0badcafe
R 000fff 0 12345678
W 3fec0a 1 0
R 3fec0a 0 00000001
W 3fec0a 0 0
R 3fec0a 0 00000000
W 3fec20 3 0
R 3fec20 0 00000003
T 0 4 1
W 3fec20 0 0
T 0 4 0
W 3ff401 0 0
W 3ff400 1 0
R 3ff400 0 00000001
T 0 60 1
W 3ff401 0 0
T 0 4 0
W 3ff400 0 0
T 1 80 0
# Disk read of block 1, 8 words to DRAM 100 with interrupt enabled
W 3dfff9 100 0
W 3dfffa 8 0
W 3dfffb 1 0
W 3dfff8 5 0
D 3dfff8 0 2
T 0 4 1
R 000100 0 a4a4a4a5
R 000101 0 a4a6a4a7
R 000102 0 a4a0a4a1
R 000103 0 a4a2a4a3
R 000104 0 a4aca4ad
R 000105 0 a4aea4af
R 000106 0 a4a8a4a9
R 000107 0 a4aaa4ab
W 3dfff8 0 0
T 0 4 0
# Disk write of DRAM 200 to block 3, then block 3 back to DRAM 300
W 000200 0f1e2d3c 0
W 000201 8796a5b4 0
W 000202 c3d2e1f0 0
W 000203 00ff00ff 0
W 3dfff9 200 0
W 3dfffa 4 0
W 3dfffb 3 0
W 3dfff8 2 0
D 3dfff8 0 2
W 3dfff9 300 0
W 3dfffa 4 0
W 3dfff8 1 0
D 3dfff8 0 2
R 000300 0 0f1e2d3c
R 000301 0 8796a5b4
R 000302 0 c3d2e1f0
R 000303 0 00ff00ff
